//--- ex_isa_pkg.sv
//--------------------------------------------------------------------
// architectural definitions for the execute stage
// data width, ALU operation codes, data sizes
// flag bit positions and the EFLAGS union
//--------------------------------------------------------------------
package ex_isa_pkg;

	localparam int unsigned data_w = 32;

	// EFLAGS bit positions
	localparam int unsigned cf_bit = 0;
	localparam int unsigned pf_bit = 2;
	localparam int unsigned af_bit = 4;
	localparam int unsigned zf_bit = 6;
	localparam int unsigned sf_bit = 7;
	localparam int unsigned of_bit = 11;

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_pass_b = 3'd5
	} alu_op_t;

	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_word  = 2'd1,
		size_dword = 2'd2,
		size_qword = 2'd3
	} data_size_t;

	// named view, laid out from the bit positions above
	typedef struct packed {
		logic [data_w-1:of_bit+1] rsvd_hi;
		logic                     of;
		logic [of_bit-1:sf_bit+1] rsvd_mid;
		logic                     sf;
		logic                     zf;
		logic [zf_bit-1:af_bit+1] rsvd_5;
		logic                     af;
		logic [af_bit-1:pf_bit+1] rsvd_3;
		logic                     pf;
		logic [pf_bit-1:cf_bit+1] rsvd_1;
		logic                     cf;
	} eflags_bits_t;

	typedef union packed {
		logic [data_w-1:0] raw;
		eflags_bits_t      bits;
	} eflags_t;

endpackage

//--- ex_pipe_pkg.sv
//--------------------------------------------------------------------
// pipeline definitions for the execute stage
// micro-op control word, operand bundle, writeback bundle
//--------------------------------------------------------------------
package ex_pipe_pkg;

	typedef struct packed {
		ex_isa_pkg::alu_op_t    aluk;
		ex_isa_pkg::data_size_t size;
		logic                   is_alu32;
		logic                   alu_flags;
		logic                   alu_to_b;
		logic                   pass_a;
		logic                   is_xchg;
		logic                   is_cmpxchg;
		logic                   cmps_first;
		logic                   cmps_second;
		logic                   repne;
		logic                   mux_sp_pop;
		logic                   ld_gpr1;
		logic                   ld_gpr2;
		logic                   dcache_write;
	} ex_ctrl_t;

	typedef struct packed {
		logic [ex_isa_pkg::data_w-1:0] a;
		logic [ex_isa_pkg::data_w-1:0] b;
		logic [ex_isa_pkg::data_w-1:0] c;
	} ex_operands_t;

	typedef struct packed {
		logic [ex_isa_pkg::data_w-1:0] result_a;
		logic [ex_isa_pkg::data_w-1:0] result_b;
		logic [ex_isa_pkg::data_w-1:0] result_c;
		ex_isa_pkg::eflags_t           flags;
		logic                          ld_gpr1;
		logic                          ld_gpr2;
		logic                          dcache_write;
		logic                          v;
	} wb_bundle_t;

endpackage

//--- operand_select_ex.sv
//--------------------------------------------------------------------
// execute stage operand selection
// cmps first-operand register, B operand and count muxes
//--------------------------------------------------------------------
`timescale 1ns/1ps

module operand_select_ex (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          adv,
	input  ex_pipe_pkg::ex_ctrl_t         ctrl,
	input  ex_pipe_pkg::ex_operands_t     ops,
	input  logic                          ex_v,
	input  logic                          steady,
	input  logic [ex_isa_pkg::data_w-1:0] count_fwd,
	output logic [ex_isa_pkg::data_w-1:0] b_sel,
	output logic [ex_isa_pkg::data_w-1:0] count_sel
);
	import ex_isa_pkg::*;

	logic [data_w-1:0] cmps_first_q;

	// first cmps micro-op leaves its A operand here for the second one
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmps_first_q <= '0;
		end else if (adv && ex_v && ctrl.cmps_first) begin
			cmps_first_q <= ops.a;
		end
	end

	// second cmps compares against the stored operand
	assign b_sel = ctrl.cmps_second ? cmps_first_q : ops.b;

	// inside a repne loop the live count comes from the stage counter
	assign count_sel = steady ? count_fwd : ops.c;

endmodule

//--- alu_ex.sv
//--------------------------------------------------------------------
// execute stage functional unit
// 32-bit ALU with EFLAGS, count-minus-one, stack pop adder
//--------------------------------------------------------------------
`timescale 1ns/1ps

module alu_ex (
	input  ex_pipe_pkg::ex_ctrl_t         ctrl,
	input  logic [ex_isa_pkg::data_w-1:0] a,
	input  logic [ex_isa_pkg::data_w-1:0] b_sel,
	input  logic [ex_isa_pkg::data_w-1:0] c,
	input  logic [ex_isa_pkg::data_w-1:0] count_sel,
	output logic [ex_isa_pkg::data_w-1:0] alu_result,
	output ex_isa_pkg::eflags_t           alu_flags,
	output logic [ex_isa_pkg::data_w-1:0] count_minus_one,
	output logic [ex_isa_pkg::data_w-1:0] sp_pop
);
	import ex_isa_pkg::*;

	localparam int unsigned msb = data_w - 1;

	logic [data_w:0]   wide;
	logic [data_w-1:0] pop_inc;
	logic              is_add;
	logic              is_sub;

	assign is_add = (ctrl.aluk == alu_add);
	assign is_sub = (ctrl.aluk == alu_sub);

	//----------------------------------------------------------------
	// ALU datapath, extra top bit carries cf / borrow
	//----------------------------------------------------------------
	always_comb begin
		unique case (ctrl.aluk)
			alu_add: wide = {1'b0, a} + {1'b0, b_sel};
			alu_sub: wide = {1'b0, a} - {1'b0, b_sel};
			alu_and: wide = {1'b0, a & b_sel};
			alu_or:  wide = {1'b0, a | b_sel};
			alu_xor: wide = {1'b0, a ^ b_sel};
			default: wide = {1'b0, b_sel};
		endcase
	end

	assign alu_result = wide[data_w-1:0];

	// flags go out through the named view, reserved bits stay zero
	always_comb begin
		alu_flags         = '0;
		alu_flags.bits.zf = (alu_result == '0);
		alu_flags.bits.sf = alu_result[msb];
		alu_flags.bits.pf = ~^alu_result[7:0];
		if (is_add || is_sub) begin
			alu_flags.bits.cf = wide[data_w];
			// carry out of bit 3
			alu_flags.bits.af = a[4] ^ b_sel[4] ^ alu_result[4];
		end
		if (is_add) begin
			alu_flags.bits.of = (a[msb] == b_sel[msb]) && (alu_result[msb] != a[msb]);
		end else if (is_sub) begin
			alu_flags.bits.of = (a[msb] != b_sel[msb]) && (alu_result[msb] != a[msb]);
		end
	end

	//----------------------------------------------------------------
	// count and stack pointer adders
	//----------------------------------------------------------------
	assign count_minus_one = count_sel - data_w'(1);

	always_comb begin
		unique case (ctrl.size)
			size_byte:  pop_inc = data_w'(1);
			size_word:  pop_inc = data_w'(2);
			size_dword: pop_inc = data_w'(4);
			default:    pop_inc = data_w'(8);
		endcase
	end

	assign sp_pop = c + pop_inc;

endmodule

//--- result_select_ex.sv
//--------------------------------------------------------------------
// execute stage result selection and writeback register
// cmpxchg write-enable decision, valid gating, result muxes
//--------------------------------------------------------------------
`timescale 1ns/1ps

module result_select_ex (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          adv,
	input  logic                          ex_v,
	input  ex_pipe_pkg::ex_ctrl_t         ctrl,
	input  ex_pipe_pkg::ex_operands_t     ops,
	input  logic [ex_isa_pkg::data_w-1:0] alu_result,
	input  ex_isa_pkg::eflags_t           alu_flags,
	input  logic [ex_isa_pkg::data_w-1:0] count_minus_one,
	input  logic [ex_isa_pkg::data_w-1:0] sp_pop,
	input  logic                          terminate,
	output ex_pipe_pkg::wb_bundle_t       wb,
	output logic                          repne_done
);
	import ex_isa_pkg::*;
	import ex_pipe_pkg::*;

	wb_bundle_t wb_next;
	logic       zf;
	logic       ld_gpr1;
	logic       ld_gpr2;
	logic       dcache_write;

	assign zf = alu_flags.raw[zf_bit];

	//----------------------------------------------------------------
	// cmpxchg: equal keeps the store, unequal loads the accumulator
	//----------------------------------------------------------------
	assign ld_gpr1      = ctrl.is_cmpxchg ? (ctrl.ld_gpr1 & zf) : ctrl.ld_gpr1;
	assign dcache_write = ctrl.is_cmpxchg ? (ctrl.dcache_write & zf) : ctrl.dcache_write;
	assign ld_gpr2      = ctrl.is_cmpxchg ? ~zf : ctrl.ld_gpr2;

	always_comb begin
		// result A, highest priority first
		if (ctrl.is_alu32) begin
			wb_next.result_a = alu_result;
		end else if (ctrl.cmps_first || ctrl.is_xchg) begin
			wb_next.result_a = ops.b;
		end else if (ctrl.pass_a) begin
			wb_next.result_a = ops.a;
		end else begin
			// cmpxchg and the default case both take C
			wb_next.result_a = ops.c;
		end

		if (ctrl.alu_to_b) begin
			wb_next.result_b = alu_result;
		end else if (ctrl.is_cmpxchg || ctrl.is_xchg) begin
			wb_next.result_b = ops.a;
		end else begin
			wb_next.result_b = ops.b;
		end

		if (ctrl.cmps_second) begin
			wb_next.result_c = count_minus_one;
		end else if (ctrl.mux_sp_pop) begin
			wb_next.result_c = sp_pop;
		end else begin
			wb_next.result_c = ops.c;
		end

		if (ctrl.alu_flags) begin
			wb_next.flags = alu_flags;
		end else begin
			wb_next.flags.raw = ops.a;
		end

		// bubble: nothing is written for an invalid micro-op
		wb_next.ld_gpr1      = ex_v & ld_gpr1;
		wb_next.ld_gpr2      = ex_v & ld_gpr2;
		wb_next.dcache_write = ex_v & dcache_write;
		wb_next.v            = ex_v;
	end

	//----------------------------------------------------------------
	// writeback register, holds while writeback stalls
	//----------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb         <= '0;
			repne_done <= 1'b0;
		end else if (adv) begin
			wb         <= wb_next;
			repne_done <= terminate;
		end
	end

endmodule

//--- repne_fsm_ex.sv
//--------------------------------------------------------------------
// repne cmps loop control
// idle / looping FSM, counter strobes, termination
//--------------------------------------------------------------------
`timescale 1ns/1ps

module repne_fsm_ex (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          adv,
	input  logic                          ex_v,
	input  ex_pipe_pkg::ex_ctrl_t         ctrl,
	input  ex_isa_pkg::eflags_t           alu_flags,
	input  logic [ex_isa_pkg::data_w-1:0] count_minus_one,
	output logic                          steady,
	output logic                          cnt_load,
	output logic                          cnt_dec,
	output logic                          terminate
);
	import ex_isa_pkg::*;

	typedef enum logic {
		st_idle    = 1'b0,
		st_looping = 1'b1
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   rep_cmps;

	assign rep_cmps = ex_v && ctrl.repne && ctrl.cmps_second;

	// loop ends on a match or when the count runs out
	assign terminate = rep_cmps && (alu_flags.raw[zf_bit] || (count_minus_one == '0));

	assign steady   = (state_q == st_looping);
	assign cnt_load = rep_cmps && !steady;
	assign cnt_dec  = rep_cmps && steady;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			st_idle: begin
				if (rep_cmps && !terminate) begin
					state_d = st_looping;
				end
			end
			default: begin
				if (terminate) begin
					state_d = st_idle;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_idle;
		end else if (adv) begin
			state_q <= state_d;
		end
	end

endmodule

//--- rep_counter_ex.sv
//--------------------------------------------------------------------
// repne loop count register
//--------------------------------------------------------------------
`timescale 1ns/1ps

module rep_counter_ex (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          adv,
	input  logic                          cnt_load,
	input  logic                          cnt_dec,
	input  logic [ex_isa_pkg::data_w-1:0] load_value,
	output logic [ex_isa_pkg::data_w-1:0] count_fwd
);
	import ex_isa_pkg::*;

	logic [data_w-1:0] count_q;

	// load_value already holds count - 1 for either strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count_q <= '0;
		end else if (adv && (cnt_load || cnt_dec)) begin
			count_q <= load_value;
		end
	end

	assign count_fwd = count_q;

endmodule

//--- ex_stage.sv
//--------------------------------------------------------------------
// execute stage top level
// operand select, ALU, repne control, counter, writeback
//--------------------------------------------------------------------
`timescale 1ns/1ps

module ex_stage (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      ex_v,
	input  ex_pipe_pkg::ex_ctrl_t     ex_ctrl,
	input  ex_pipe_pkg::ex_operands_t ex_ops,
	input  logic                      wb_stall,
	output ex_pipe_pkg::wb_bundle_t   wb,
	output logic                      repne_done
);
	import ex_isa_pkg::*;

	logic              adv;
	logic [data_w-1:0] b_sel;
	logic [data_w-1:0] count_sel;
	logic [data_w-1:0] count_fwd;
	logic [data_w-1:0] alu_result;
	logic [data_w-1:0] count_minus_one;
	logic [data_w-1:0] sp_pop;
	eflags_t           alu_flags;
	logic              steady;
	logic              cnt_load;
	logic              cnt_dec;
	logic              terminate;

	// every register in the stage freezes under back-pressure
	assign adv = ~wb_stall;

	operand_select_ex operand_select_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.adv       (adv),
		.ctrl      (ex_ctrl),
		.ops       (ex_ops),
		.ex_v      (ex_v),
		.steady    (steady),
		.count_fwd (count_fwd),
		.b_sel     (b_sel),
		.count_sel (count_sel)
	);

	alu_ex alu_i (
		.ctrl            (ex_ctrl),
		.a               (ex_ops.a),
		.b_sel           (b_sel),
		.c               (ex_ops.c),
		.count_sel       (count_sel),
		.alu_result      (alu_result),
		.alu_flags       (alu_flags),
		.count_minus_one (count_minus_one),
		.sp_pop          (sp_pop)
	);

	repne_fsm_ex repne_fsm_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.adv             (adv),
		.ex_v            (ex_v),
		.ctrl            (ex_ctrl),
		.alu_flags       (alu_flags),
		.count_minus_one (count_minus_one),
		.steady          (steady),
		.cnt_load        (cnt_load),
		.cnt_dec         (cnt_dec),
		.terminate       (terminate)
	);

	rep_counter_ex rep_counter_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.adv        (adv),
		.cnt_load   (cnt_load),
		.cnt_dec    (cnt_dec),
		.load_value (count_minus_one),
		.count_fwd  (count_fwd)
	);

	result_select_ex result_select_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.adv             (adv),
		.ex_v            (ex_v),
		.ctrl            (ex_ctrl),
		.ops             (ex_ops),
		.alu_result      (alu_result),
		.alu_flags       (alu_flags),
		.count_minus_one (count_minus_one),
		.sp_pop          (sp_pop),
		.terminate       (terminate),
		.wb              (wb),
		.repne_done      (repne_done)
	);

endmodule

//--- ex_stage_assert.sv
//--------------------------------------------------------------------
// concurrent checks on execute stage control outputs
// bound into ex_stage
//--------------------------------------------------------------------
`timescale 1ns/1ps

module ex_stage_assert (
	input logic                    clk,
	input logic                    arst_n,
	input ex_pipe_pkg::wb_bundle_t wb,
	input logic                    repne_done,
	input logic                    cnt_load,
	input logic                    cnt_dec
);

	// a bubble never writes anything
	enables_need_valid: assert property (@(posedge clk) disable iff (!arst_n)
		!wb.v |-> !(wb.ld_gpr1 || wb.ld_gpr2 || wb.dcache_write))
		else $error("write enable high on an invalid writeback");

	// counter strobes are exclusive
	load_dec_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(cnt_load && cnt_dec))
		else $error("cnt_load and cnt_dec high together");

	done_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
		repne_done |-> wb.v)
		else $error("repne_done without a valid writeback");

endmodule

bind ex_stage ex_stage_assert ex_stage_assert_i (
	.clk        (clk),
	.arst_n     (arst_n),
	.wb         (wb),
	.repne_done (repne_done),
	.cnt_load   (cnt_load),
	.cnt_dec    (cnt_dec)
);

//--- ex_stage_tb.sv
//--------------------------------------------------------------------
// execute stage testbench
// clock and reset, micro-ops and expected writeback read from
// ex_stage_input.txt, per-cycle checks of the writeback bundle
//--------------------------------------------------------------------
`timescale 1ns/1ps

module ex_stage_tb;
	import ex_isa_pkg::*;
	import ex_pipe_pkg::*;

	localparam int unsigned reset_cycles = 8;
	// polls of half a period, so four clock cycles
	localparam int unsigned edge_timeout = 8;

	// one line of the input file
	typedef struct packed {
		logic         v;
		logic         stall;
		ex_ctrl_t     ctrl;
		ex_operands_t ops;
		wb_bundle_t   exp_wb;
		logic         exp_done;
	} step_t;

	logic         clk;
	logic         arst_n;
	logic         ex_v;
	ex_ctrl_t     ex_ctrl;
	ex_operands_t ex_ops;
	logic         wb_stall;
	wb_bundle_t   wb;
	logic         repne_done;

	int    fd;
	string line;
	string test_name;
	string prev_name;
	step_t cur;
	step_t prev;
	logic  have_prev;
	logic  got_step;
	logic  saw_end;
	int    step_no;
	int    prev_no;

	ex_stage dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.ex_v       (ex_v),
		.ex_ctrl    (ex_ctrl),
		.ex_ops     (ex_ops),
		.wb_stall   (wb_stall),
		.wb         (wb),
		.repne_done (repne_done)
	);

	always #2 clk = ~clk;

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "testbench stopped at the first error");
	endtask

	// called on odd ns only, so a poll never lands on a clock transition;
	// returns 1 ns after the next rising edge
	task automatic wait_drive_point();
		int unsigned n;
		n = 0;
		while (clk !== 1'b0 && n < edge_timeout) begin
			#2;
			n++;
		end
		while (clk !== 1'b1 && n < edge_timeout) begin
			#2;
			n++;
		end
		if (clk !== 1'b1 || n >= edge_timeout) begin
			$display("no rising clock edge within 4 cycles, the clock has stopped");
			fail_run();
		end
	endtask

	//----------------------------------------------------------------
	// input file parsing
	//----------------------------------------------------------------
	task automatic fetch_step(output logic got);
		int           n;
		int           r;
		logic         v;
		logic         st;
		logic [2:0]   op;
		logic [1:0]   sz;
		logic [12:0]  cbits;
		logic [31:0]  a;
		logic [31:0]  b;
		logic [31:0]  c;
		logic         ev;
		logic [31:0]  ea;
		logic [31:0]  eb;
		logic [31:0]  ec;
		logic [31:0]  ef;
		logic [2:0]   en;
		logic         ed;
		got = 1'b0;
		while (!got && !saw_end && !$feof(fd)) begin
			r = $fgets(line, fd);
			if (r == 0) begin
				line = "";
			end
			n = $sscanf(line, "%h %h %h %h %b %h %h %h %h %h %h %h %h %b %h",
				v, st, op, sz, cbits, a, b, c, ev, ea, eb, ec, ef, en, ed);
			if (n == 15) begin
				cur.v                   = v;
				cur.stall               = st;
				cur.ctrl                = ex_ctrl_t'({op, sz, cbits});
				cur.ops                 = {a, b, c};
				cur.exp_wb.v            = ev;
				cur.exp_wb.result_a     = ea;
				cur.exp_wb.result_b     = eb;
				cur.exp_wb.result_c     = ec;
				cur.exp_wb.flags.raw    = ef;
				cur.exp_wb.ld_gpr1      = en[2];
				cur.exp_wb.ld_gpr2      = en[1];
				cur.exp_wb.dcache_write = en[0];
				cur.exp_done            = ed;
				got = 1'b1;
			end else if (line.substr(0, 0) == "@") begin
				r = $sscanf(line, "@ %s", test_name);
			end else if (line.substr(0, 2) == "end") begin
				saw_end = 1'b1;
			end else if (line.substr(0, 0) != "#" && line.len() > 1) begin
				$display("malformed line in the input file: %s", line);
				fail_run();
			end
		end
	endtask

	task automatic apply_step(input step_t s);
		ex_v     = s.v;
		wb_stall = s.stall;
		ex_ctrl  = s.ctrl;
		ex_ops   = s.ops;
	endtask

	//----------------------------------------------------------------
	// checks
	//----------------------------------------------------------------
	task automatic check_value(input string name, input int idx, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error: test %s step %0d %s expected %h actual %h",
				name, idx, field, expected, actual);
			fail_run();
		end
	endtask

	task automatic check_step(input step_t s, input string name, input int idx);
		wb_bundle_t e;
		e = s.exp_wb;
		check_value(name, idx, "v", 32'(e.v), 32'(wb.v));
		check_value(name, idx, "write enables",
			32'({e.ld_gpr1, e.ld_gpr2, e.dcache_write}),
			32'({wb.ld_gpr1, wb.ld_gpr2, wb.dcache_write}));
		check_value(name, idx, "repne_done", 32'(s.exp_done), 32'(repne_done));
		// a bubble carries no meaningful results
		if (e.v) begin
			check_value(name, idx, "result_a", e.result_a, wb.result_a);
			check_value(name, idx, "result_b", e.result_b, wb.result_b);
			check_value(name, idx, "result_c", e.result_c, wb.result_c);
			check_value(name, idx, "flags", e.flags.raw, wb.flags.raw);
		end
	endtask

	initial begin
		clk       = 1'b0;
		arst_n    = 1'b0;
		ex_v      = 1'b0;
		ex_ctrl   = '0;
		ex_ops    = '0;
		wb_stall  = 1'b0;
		have_prev = 1'b0;
		saw_end   = 1'b0;
		step_no   = 0;
		prev_no   = 0;
		test_name = "none";
		fd = $fopen("ex_stage_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open ex_stage_input.txt");
			fail_run();
		end
		#1;
		repeat (reset_cycles) wait_drive_point();
		arst_n = 1'b1;

		// each step checks the writeback of the step before it
		fetch_step(got_step);
		while (got_step) begin
			wait_drive_point();
			apply_step(cur);
			#2;
			if (have_prev) begin
				check_step(prev, prev_name, prev_no);
			end
			prev      = cur;
			prev_name = test_name;
			prev_no   = step_no;
			have_prev = 1'b1;
			step_no++;
			fetch_step(got_step);
		end
		$fclose(fd);

		if (!saw_end) begin
			$display("the input file ended before its end marker");
			fail_run();
		end else begin
			// idle cycle pushes the last micro-op out
			wait_drive_point();
			ex_v     = 1'b0;
			wb_stall = 1'b0;
			ex_ctrl  = '0;
			ex_ops   = '0;
			#2;
			if (have_prev) begin
				check_step(prev, prev_name, prev_no);
			end
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- ex_stage_input.txt
# v stall aluk size ctrl(alu32 flg to_b pass_a xchg cmpxchg cf cs repne pop g1 g2 dw) a b c
#   exp: v result_a result_b result_c flags enables(g1 g2 dw) repne_done
@ alu_ops
1 0 0 2 1100000000100 ffffffff 00000001 00000000 1 00000000 00000001 00000000 00000055 100 0
1 0 1 2 1100000000100 00000003 00000005 00000000 1 fffffffe 00000005 00000000 00000091 100 0
1 0 1 2 1100000000100 80000000 00000001 00000000 1 7fffffff 00000001 00000000 00000814 100 0
1 0 2 2 1100000000100 f0f0f0f0 0ff00ff0 00000000 1 00f000f0 0ff00ff0 00000000 00000004 100 0
1 0 3 2 1100000000100 80000000 00000001 00000000 1 80000001 00000001 00000000 00000080 100 0
1 0 4 2 1100000000100 12345678 12345678 00000000 1 00000000 12345678 00000000 00000044 100 0
@ xchg_pop
1 0 5 0 0000100000110 aaaa0001 bbbb0002 00000010 1 bbbb0002 aaaa0001 00000010 aaaa0001 110 0
1 0 5 0 0001000001110 00000011 00000000 00001000 1 00000011 00000000 00001001 00000011 110 0
1 0 5 1 0001000001110 00000022 00000000 00001000 1 00000022 00000000 00001002 00000022 110 0
1 0 5 2 0001000001110 00000044 00000000 0000fffe 1 00000044 00000000 00010002 00000044 110 0
1 0 5 3 0001000001110 00000088 00000000 fffffffc 1 00000088 00000000 00000004 00000088 110 0
@ cmpxchg
1 0 1 2 0100010000101 00000042 00000042 00000099 1 00000099 00000042 00000099 00000044 101 0
1 0 1 2 0100010000101 00000042 00000043 00000099 1 00000099 00000042 00000099 00000095 010 0
@ repne_count
1 0 5 2 0000001000100 00000010 00001000 00000003 1 00001000 00001000 00000003 00000010 100 0
1 0 1 2 0100000110010 00000005 00002000 00000003 1 00000003 00002000 00000002 00000085 010 0
1 0 5 2 0000001000100 00000010 00001000 00000003 1 00001000 00001000 00000003 00000010 100 0
1 0 1 2 0100000110010 00000005 00002000 00000003 1 00000003 00002000 00000001 00000085 010 0
1 0 5 2 0000001000100 00000010 00001000 00000003 1 00001000 00001000 00000003 00000010 100 0
1 0 1 2 0100000110010 00000005 00002000 00000003 1 00000003 00002000 00000000 00000085 010 1
@ repne_match
1 0 5 2 0000001000100 00000030 00001000 00000005 1 00001000 00001000 00000005 00000030 100 0
1 0 1 2 0100000110010 00000031 00002000 00000005 1 00000005 00002000 00000004 00000000 010 0
1 0 5 2 0000001000100 00000040 00001000 00000005 1 00001000 00001000 00000005 00000040 100 0
1 0 1 2 0100000110010 00000040 00002000 00000005 1 00000005 00002000 00000003 00000044 010 1
@ stall_hold
1 0 0 2 1100000000100 00000100 00000200 00000000 1 00000300 00000200 00000000 00000004 100 0
1 1 1 2 1100000000100 00000010 00000001 00000007 1 00000300 00000200 00000000 00000004 100 0
1 1 1 2 1100000000100 00000010 00000001 00000007 1 00000300 00000200 00000000 00000004 100 0
1 1 1 2 1100000000100 00000010 00000001 00000007 1 00000300 00000200 00000000 00000004 100 0
1 0 1 2 1100000000100 00000010 00000001 00000007 1 0000000f 00000001 00000007 00000014 100 0
@ bubble
0 0 1 2 0100010000101 00000042 00000042 00000099 0 00000000 00000000 00000000 00000000 000 0
end

//--- ex_stage.f
ex_isa_pkg.sv
ex_pipe_pkg.sv
operand_select_ex.sv
alu_ex.sv
result_select_ex.sv
repne_fsm_ex.sv
rep_counter_ex.sv
ex_stage.sv
ex_stage_assert.sv
ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the execute stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module ex_stage_tb \
	-f ex_stage.f -o ex_stage_sim &&
{ out=$(./obj_dir/ex_stage_sim); echo "$out"; \
	echo "$out" | grep -q "Simulation completed successfully"; } &&
echo "PASS" || { echo "FAIL"; exit 1; }
